// File: src/tbu_pkg.sv
`default_nettype none

package tbu_pkg;

  // -------------------------------------------------------------------
  // numerology constants
  // -------------------------------------------------------------------

  // normal cp, 14 ofdm symbols in every slot
  localparam int SYMB_PER_SLOT = 14;

  // system frame number wraps at 1024
  localparam int FRAME_NUM_W = 10;

  // phase inside a frame and config offsets, in clock cycles
  localparam int PHASE_W = 16;

  // -------------------------------------------------------------------
  // bundles
  // -------------------------------------------------------------------

  // head placement relative to the 10 ms boundary
  typedef struct packed {
    logic [PHASE_W-1:0] dl_delay;   // boundary to dl head
    logic [PHASE_W-1:0] ul_gap;     // dl head to ul head
  } tbu_cfg_t;

  // single-cycle frame head with the number of the frame it opens
  typedef struct packed {
    logic                   vld;
    logic [FRAME_NUM_W-1:0] frame_num;
  } frame_head_t;

  // per-direction counters and their head strobes
  typedef struct packed {
    logic [FRAME_NUM_W-1:0] frame_num;
    logic                   half_frame_num;
    logic [5:0]             slot_num;
    logic [3:0]             symb_num;
    logic                   frame_head;
    logic                   half_frame_head;
    logic                   slot_head;
    logic                   symb_head;
  } frame_info_t;

  // info generator state, idle until the first head arrives
  typedef enum logic {
    IDLE,
    RUN
  } info_state_t;

endpackage

`default_nettype wire

// File: src/tbu_frame_timer.sv
`default_nettype none

module tbu_frame_timer
  import tbu_pkg::*;
#(
  parameter int SYM_LEN         = 4,
  parameter int LONG_EXTRA      = 2,
  parameter int SLOTS_PER_FRAME = 4
)
(
  input  wire                     clk,
  input  wire                     rst,
  output logic                    o_frame_pulse,
  output logic [PHASE_W-1:0]      o_phase,
  output logic [FRAME_NUM_W-1:0]  o_frame_num
);

  // one frame = all slots, each 14 symbols plus the long cp extra
  localparam int FRAME_LEN = SLOTS_PER_FRAME * (SYMB_PER_SLOT * SYM_LEN + LONG_EXTRA);

  logic wrap;

  // -------------------------------------------------------------------
  // internal 10 ms reference
  // -------------------------------------------------------------------

  // last cycle of the frame
  assign wrap = (o_phase == PHASE_W'(FRAME_LEN - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_phase     <= '0;
      o_frame_num <= '0;
    end
    else if (wrap)
    begin
      o_phase     <= '0;
      // new number shows together with phase 0, held all frame
      o_frame_num <= o_frame_num + 1'b1;
    end
    else
    begin
      o_phase <= o_phase + 1'b1;
    end
  end

  // boundary marker, first one right after reset release
  assign o_frame_pulse = (o_phase == '0);

  // frame boundary is a strobe, never two cycles long
  a_pulse_single : assert property (@(posedge clk) disable iff (rst)
    o_frame_pulse |=> !o_frame_pulse);

endmodule

`default_nettype wire

// File: src/tbu_head_align.sv
`default_nettype none

module tbu_head_align
  import tbu_pkg::*;
#(
  parameter int SYM_LEN         = 4,
  parameter int LONG_EXTRA      = 2,
  parameter int SLOTS_PER_FRAME = 4
)
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_frame_pulse,
  input  wire [PHASE_W-1:0]       i_phase,
  input  wire [FRAME_NUM_W-1:0]   i_frame_num,
  input  wire tbu_cfg_t           i_cfg,
  output frame_head_t             o_dl_head,
  output frame_head_t             o_ul_head
);

  localparam int FRAME_LEN = SLOTS_PER_FRAME * (SYMB_PER_SLOT * SYM_LEN + LONG_EXTRA);

  tbu_cfg_t           cfg_q;
  tbu_cfg_t           cfg_act;
  logic [PHASE_W:0]   ul_sum;
  logic [PHASE_W-1:0] ul_match;
  logic               dl_hit;
  logic               ul_hit;

  // -------------------------------------------------------------------
  // config capture
  // -------------------------------------------------------------------

  // working copy, only reloaded on the frame boundary
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cfg_q <= '0;
    end
    else if (i_frame_pulse)
    begin
      cfg_q <= i_cfg;
    end
  end

  // on the boundary cycle itself the new value already counts
  // so a zero delay still hits phase 0 of this frame
  assign cfg_act = i_frame_pulse ? i_cfg : cfg_q;

  // -------------------------------------------------------------------
  // match phases
  // -------------------------------------------------------------------

  // ul sits dl_delay + ul_gap after the boundary
  assign ul_sum = {1'b0, cfg_act.dl_delay} + {1'b0, cfg_act.ul_gap};

  // past the frame end it lands in the next frame
  assign ul_match = (ul_sum >= (PHASE_W + 1)'(FRAME_LEN)) ?
                    PHASE_W'(ul_sum - (PHASE_W + 1)'(FRAME_LEN)) :
                    ul_sum[PHASE_W-1:0];

  assign dl_hit = (i_phase == cfg_act.dl_delay);
  assign ul_hit = (i_phase == ul_match);

  // -------------------------------------------------------------------
  // head strobes, one cycle after the match
  // -------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_dl_head <= '0;
      o_ul_head <= '0;
    end
    else
    begin
      o_dl_head.vld       <= dl_hit;
      o_dl_head.frame_num <= i_frame_num;
      o_ul_head.vld       <= ul_hit;
      // number of the frame the match falls in
      o_ul_head.frame_num <= i_frame_num;
    end
  end

  // loaded offsets must stay inside one frame
  a_cfg_range : assert property (@(posedge clk) disable iff (rst)
    $past(i_frame_pulse) |-> (cfg_q.dl_delay < PHASE_W'(FRAME_LEN)) &&
                             (cfg_q.ul_gap < PHASE_W'(FRAME_LEN)));

endmodule

`default_nettype wire

// File: src/tbu_frame_info_gen.sv
`default_nettype none

module tbu_frame_info_gen
  import tbu_pkg::*;
#(
  parameter int SYM_LEN         = 4,
  parameter int LONG_EXTRA      = 2,
  parameter int SLOTS_PER_FRAME = 4
)
(
  input  wire               clk,
  input  wire               rst,
  input  wire frame_head_t  i_head,
  output frame_info_t       o_info
);

  localparam int FRAME_LEN = SLOTS_PER_FRAME * (SYMB_PER_SLOT * SYM_LEN + LONG_EXTRA);

  // sample counter wide enough for any symbol of the frame
  localparam int CNT_W = $clog2(FRAME_LEN);

  info_state_t            state;
  logic [CNT_W-1:0]       samp_cnt;
  logic [CNT_W-1:0]       samp_last;
  logic [3:0]             symb_cnt;
  logic [5:0]             slot_cnt;
  logic [FRAME_NUM_W-1:0] frame_num;
  logic                   symb_end;
  logic                   slot_end;
  logic                   frame_end;
  logic                   run;
  logic                   symb_head;
  logic                   slot_head;

  // -------------------------------------------------------------------
  // state
  // -------------------------------------------------------------------

  // idle until the first head, then counting for good
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else if (i_head.vld)
    begin
      state <= RUN;
    end
  end

  assign run = (state == RUN);

  // -------------------------------------------------------------------
  // numerology counters
  // -------------------------------------------------------------------

  // symbol 0 carries the extended cp
  assign samp_last = (symb_cnt == 4'd0) ? CNT_W'(SYM_LEN + LONG_EXTRA - 1) :
                                          CNT_W'(SYM_LEN - 1);

  assign symb_end  = (samp_cnt == samp_last);
  assign slot_end  = symb_end && (symb_cnt == 4'(SYMB_PER_SLOT - 1));
  assign frame_end = slot_end && (slot_cnt == 6'(SLOTS_PER_FRAME - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      samp_cnt  <= '0;
      symb_cnt  <= '0;
      slot_cnt  <= '0;
      frame_num <= '0;
    end
    else if (i_head.vld)
    begin
      // head always restarts the frame
      samp_cnt  <= '0;
      symb_cnt  <= '0;
      slot_cnt  <= '0;
      frame_num <= i_head.frame_num;
    end
    else if (run)
    begin
      if (frame_end)
      begin
        // no head came, roll over and keep the number
        samp_cnt <= '0;
        symb_cnt <= '0;
        slot_cnt <= '0;
      end
      else if (slot_end)
      begin
        samp_cnt <= '0;
        symb_cnt <= '0;
        slot_cnt <= slot_cnt + 1'b1;
      end
      else if (symb_end)
      begin
        samp_cnt <= '0;
        symb_cnt <= symb_cnt + 1'b1;
      end
      else
      begin
        samp_cnt <= samp_cnt + 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------
  // outputs
  // -------------------------------------------------------------------

  // first sample of each symbol, gated until running
  assign symb_head = run && (samp_cnt == '0);
  assign slot_head = symb_head && (symb_cnt == 4'd0);

  assign o_info.frame_num       = frame_num;
  // second half starts at the middle slot
  assign o_info.half_frame_num  = (slot_cnt >= 6'(SLOTS_PER_FRAME / 2));
  assign o_info.slot_num        = slot_cnt;
  assign o_info.symb_num        = symb_cnt;
  assign o_info.frame_head      = slot_head && (slot_cnt == 6'd0);
  assign o_info.half_frame_head = slot_head && ((slot_cnt == 6'd0) ||
                                  (slot_cnt == 6'(SLOTS_PER_FRAME / 2)));
  assign o_info.slot_head       = slot_head;
  assign o_info.symb_head       = symb_head;

  // counters stay inside the numerology
  a_symb_range : assert property (@(posedge clk) disable iff (rst)
    o_info.symb_num < 4'(SYMB_PER_SLOT));

  a_slot_range : assert property (@(posedge clk) disable iff (rst)
    o_info.slot_num < 6'(SLOTS_PER_FRAME));

endmodule

`default_nettype wire

// File: src/tbu_top.sv
`default_nettype none

module tbu_top
  import tbu_pkg::*;
#(
  parameter int SYM_LEN         = 4,
  parameter int LONG_EXTRA      = 2,
  parameter int SLOTS_PER_FRAME = 4
)
(
  input  wire             clk,
  input  wire             rst,
  input  wire tbu_cfg_t   i_cfg,
  output logic            o_frame_head,
  output frame_info_t     o_dl_info,
  output frame_info_t     o_ul_info
);

  logic                   frame_pulse;
  logic [PHASE_W-1:0]     phase;
  logic [FRAME_NUM_W-1:0] frame_num;
  frame_head_t            dl_head;
  frame_head_t            ul_head;

  // -------------------------------------------------------------------
  // 10 ms reference and head placement
  // -------------------------------------------------------------------

  tbu_frame_timer #(
    .SYM_LEN         (SYM_LEN),
    .LONG_EXTRA      (LONG_EXTRA),
    .SLOTS_PER_FRAME (SLOTS_PER_FRAME)
  ) u_frame_timer (
    .clk           (clk),
    .rst           (rst),
    .o_frame_pulse (frame_pulse),
    .o_phase       (phase),
    .o_frame_num   (frame_num)
  );

  tbu_head_align #(
    .SYM_LEN         (SYM_LEN),
    .LONG_EXTRA      (LONG_EXTRA),
    .SLOTS_PER_FRAME (SLOTS_PER_FRAME)
  ) u_head_align (
    .clk           (clk),
    .rst           (rst),
    .i_frame_pulse (frame_pulse),
    .i_phase       (phase),
    .i_frame_num   (frame_num),
    .i_cfg         (i_cfg),
    .o_dl_head     (dl_head),
    .o_ul_head     (ul_head)
  );

  // raw boundary goes out as well
  assign o_frame_head = frame_pulse;

  // -------------------------------------------------------------------
  // per-direction counters
  // -------------------------------------------------------------------

  tbu_frame_info_gen #(
    .SYM_LEN         (SYM_LEN),
    .LONG_EXTRA      (LONG_EXTRA),
    .SLOTS_PER_FRAME (SLOTS_PER_FRAME)
  ) u_info_dl (
    .clk    (clk),
    .rst    (rst),
    .i_head (dl_head),
    .o_info (o_dl_info)
  );

  tbu_frame_info_gen #(
    .SYM_LEN         (SYM_LEN),
    .LONG_EXTRA      (LONG_EXTRA),
    .SLOTS_PER_FRAME (SLOTS_PER_FRAME)
  ) u_info_ul (
    .clk    (clk),
    .rst    (rst),
    .i_head (ul_head),
    .o_info (o_ul_info)
  );

endmodule

`default_nettype wire

// File: tb/tbu_tb.sv
`default_nettype none

module tbu_tb
  import tbu_pkg::*;
();

  localparam int SYM_LEN         = 4;
  localparam int LONG_EXTRA      = 2;
  localparam int SLOTS_PER_FRAME = 4;
  localparam int LEN0            = SYM_LEN + LONG_EXTRA;
  localparam int SLOT_LEN        = SYMB_PER_SLOT * SYM_LEN + LONG_EXTRA;
  localparam int FRAME_LEN       = SLOTS_PER_FRAME * SLOT_LEN;
  localparam int RST_CYC         = 8;
  localparam int RUN_FRAMES      = 14;
  // 14 checked frames plus reset, about 16 frames in all
  localparam int TIMEOUT_CYC     = 4000;

  logic        clk;
  logic        rst;
  tbu_cfg_t    cfg;
  logic        frame_head;
  frame_info_t dl_info;
  frame_info_t ul_info;

  // reference model, index 0 is dl and 1 is ul
  int                     cyc = 0;
  int                     tot_cyc = 0;
  int                     err_cnt = 0;
  tbu_cfg_t               cfg_act;
  int                     match [2];
  bit                     hit_d1 [2];
  bit                     hit_d2 [2];
  logic [FRAME_NUM_W-1:0] fn_d1 [2];
  logic [FRAME_NUM_W-1:0] fn_d2 [2];
  bit                     running [2];
  int                     since_head [2];
  logic [FRAME_NUM_W-1:0] head_fn [2];

  tbu_top UUT (
    .clk          (clk),
    .rst          (rst),
    .i_cfg        (cfg),
    .o_frame_head (frame_head),
    .o_dl_info    (dl_info),
    .o_ul_info    (ul_info)
  );

  // -------------------------------------------------------------------
  // helpers
  // -------------------------------------------------------------------

  task automatic report_failure();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    assert (act == exp)
    else
    begin
      err_cnt++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h (cycle %0d)", name, exp, act, cyc);
      report_failure();
    end
  endtask

  // counts only mean something once running, strobes always
  task automatic check_info(input string name, input frame_info_t exp,
                            input frame_info_t act, input bit run);
    if (run)
    begin
      check_value({name, ".frame_num"}, int'(exp.frame_num), int'(act.frame_num));
      check_value({name, ".half_frame_num"}, int'(exp.half_frame_num),
                  int'(act.half_frame_num));
      check_value({name, ".slot_num"}, int'(exp.slot_num), int'(act.slot_num));
      check_value({name, ".symb_num"}, int'(exp.symb_num), int'(act.symb_num));
    end
    check_value({name, ".frame_head"}, int'(exp.frame_head), int'(act.frame_head));
    check_value({name, ".half_frame_head"}, int'(exp.half_frame_head),
                int'(act.half_frame_head));
    check_value({name, ".slot_head"}, int'(exp.slot_head), int'(act.slot_head));
    check_value({name, ".symb_head"}, int'(exp.symb_head), int'(act.symb_head));
  endtask

  // numerology straight from the offset since the last head
  function automatic frame_info_t expected_info(input int since,
                                                input logic [FRAME_NUM_W-1:0] fn);
    int          off;
    int          slot;
    int          pos;
    int          symb;
    bit          sh;
    frame_info_t e;
    off  = since % FRAME_LEN;
    slot = off / SLOT_LEN;
    pos  = off % SLOT_LEN;
    // long symbol 0 first, then 13 short ones
    if (pos < LEN0)
    begin
      symb = 0;
      sh   = (pos == 0);
    end
    else
    begin
      symb = 1 + (pos - LEN0) / SYM_LEN;
      sh   = ((pos - LEN0) % SYM_LEN) == 0;
    end
    e.frame_num       = fn;
    e.half_frame_num  = (slot >= SLOTS_PER_FRAME / 2);
    e.slot_num        = 6'(slot);
    e.symb_num        = 4'(symb);
    e.symb_head       = sh;
    e.slot_head       = sh && (symb == 0);
    e.half_frame_head = e.slot_head && ((slot == 0) || (slot == SLOTS_PER_FRAME / 2));
    e.frame_head      = e.slot_head && (slot == 0);
    return e;
  endfunction

  // random offsets below one frame, optionally forcing the ul wrap
  function automatic tbu_cfg_t pick_config(input bit wrap_ul);
    int       d;
    int       g;
    tbu_cfg_t c;
    if (wrap_ul)
    begin
      d = FRAME_LEN / 2 + int'($urandom % (FRAME_LEN / 2));
      g = FRAME_LEN - d + int'($urandom % d);
    end
    else
    begin
      d = int'($urandom % FRAME_LEN);
      g = int'($urandom % FRAME_LEN);
    end
    c.dl_delay = PHASE_W'(d);
    c.ul_gap   = PHASE_W'(g);
    return c;
  endfunction

  // -------------------------------------------------------------------
  // clock, reset, stimulus
  // -------------------------------------------------------------------

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    int at_sample;
    void'($urandom(62));
    rst = 1'b1;
    cfg = '{dl_delay: 16'd10, ul_gap: 16'd30};
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    at_sample = 0;
    // mid-frame changes from frame 4 on, each held two frames
    for (int k = 0; k < 4; k++)
    begin
      repeat ((4 + 2 * k) * FRAME_LEN + 100 - at_sample) @(posedge clk);
      at_sample = (4 + 2 * k) * FRAME_LEN + 100;
      cfg <= pick_config(k == 1);
    end
    repeat (RUN_FRAMES * FRAME_LEN - at_sample) @(posedge clk);
    if (err_cnt == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("%0d checks failed", err_cnt);
      report_failure();
    end
  end

  always @(posedge clk)
  begin
    tot_cyc = tot_cyc + 1;
    if (tot_cyc >= TIMEOUT_CYC)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      report_failure();
    end
  end

  // -------------------------------------------------------------------
  // reference model and checks
  // -------------------------------------------------------------------

  // boundary marker on phase 0 and nowhere else
  a_frame_head : assert property (@(posedge clk) disable iff (rst)
    frame_head == ((cyc % FRAME_LEN) == 0))
    else
    begin
      err_cnt++;
      $display("[FAIL] o_frame_head expected 0x%0h got 0x%0h",
               !$sampled(frame_head), $sampled(frame_head));
      report_failure();
    end

  always @(posedge clk)
  begin : model
    int                     phase;
    logic [FRAME_NUM_W-1:0] cur_fn;
    frame_info_t            exp_info;
    frame_info_t            act;
    string                  name;
    if (!rst)
    begin
      phase  = cyc % FRAME_LEN;
      cur_fn = FRAME_NUM_W'(cyc / FRAME_LEN);
      // config loads on the boundary and holds for the frame
      if (phase == 0)
        cfg_act = cfg;
      match[0] = int'(cfg_act.dl_delay);
      match[1] = (int'(cfg_act.dl_delay) + int'(cfg_act.ul_gap)) % FRAME_LEN;
      for (int d = 0; d < 2; d++)
      begin
        act  = (d == 0) ? dl_info : ul_info;
        name = (d == 0) ? "o_dl_info" : "o_ul_info";
        // match, then head register, then info outputs
        if (hit_d2[d])
        begin
          running[d]    = 1'b1;
          since_head[d] = 0;
          head_fn[d]    = fn_d2[d];
        end
        else if (running[d])
        begin
          since_head[d] = since_head[d] + 1;
        end
        exp_info = running[d] ? expected_info(since_head[d], head_fn[d]) : '0;
        check_info(name, exp_info, act, running[d]);
        hit_d2[d] = hit_d1[d];
        fn_d2[d]  = fn_d1[d];
        hit_d1[d] = (phase == match[d]);
        fn_d1[d]  = cur_fn;
      end
      cyc = cyc + 1;
    end
  end

endmodule

`default_nettype wire

// File: tbu_top.f
src/tbu_pkg.sv
src/tbu_frame_timer.sv
src/tbu_head_align.sv
src/tbu_frame_info_gen.sv
src/tbu_top.sv
tb/tbu_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the time base unit with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbu_tb -f tbu_top.f -o tbu_sim \
  && ./obj_dir/tbu_sim 2>&1 | tee sim.log

grep -Fqx '*** TEST PASSED ***' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
